//--- vlog.f
src/cordic_pkg.sv
src/cordic_op_if.sv
src/cordic_regs.sv
src/cordic_engine.sv
src/cordic_top.sv
verif/cordic_props.sv
verif/tb_cordic.sv

//--- Makefile
TOP = tb_cordic

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_cordic.sv
`timescale 1ns/100ps

module tb_cordic import cordic_pkg::*; ();

    localparam int N_DIR    = 11;
    localparam int N_RAND   = 20;
    localparam int ACK_WAIT = 16;
    localparam int POLL_MAX = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;

    // Directed entries with expected columns from the model
    int tbl_x   [N_DIR] = '{1500, -1200, -1000,   700, -2000, 1024,   800,  1200, -900,  600,   500};
    int tbl_y   [N_DIR] = '{ 800,   900, -1300, -1600,     0,    0,  -600,   400,  700,  600,  -300};
    int tbl_z   [N_DIR] = '{   0,   300,     0,     0,     0,  804, -1500, -2500, 2600, 1785, -1786};
    bit tbl_vec [N_DIR] = '{   1,     1,     1,     1,     1,    0,     0,     0,    0,    0,     0};
    int exp_x   [N_DIR];
    int exp_y   [N_DIR];
    int exp_z   [N_DIR];

    int pass_cnt;
    int fail_cnt;
    int seed;
    bit cur_ok;

    cordic_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fixed-point CORDIC in 14-bit wrapping arithmetic
    task automatic model_op(input int x_in, input int y_in, input int z_in, input bit vec,
                            output int x_out, output int y_out, output int z_out);
        logic signed [DATA_W-1:0]   x;
        logic signed [DATA_W-1:0]   y;
        logic signed [DATA_W-1:0]   z;
        logic signed [DATA_W-1:0]   x_old;
        logic signed [2*DATA_W-1:0] prod;
        bit                         invert;
        x      = x_in[DATA_W-1:0];
        y      = y_in[DATA_W-1:0];
        z      = z_in[DATA_W-1:0];
        invert = 1'b0;
        if (vec) begin
            z = '0;
            if (x < 0) begin
                z = (y >= 0) ? PI_FIXED : -PI_FIXED;
                x = -x;
                y = -y;
            end
        end else if (z < -1786) begin
            z      = z + PI_FIXED;
            invert = 1'b1;
        end else if (z > 1785) begin
            z      = z - PI_FIXED;
            invert = 1'b1;
        end
        for (int i = 0; i < ITERATIONS; i++) begin
            x_old = x;
            if ((vec && y > 0) || (!vec && z < 0)) begin
                x = x + (y >>> i);
                y = y - (x_old >>> i);
                z = z + ATAN_TABLE[i];
            end else begin
                x = x - (y >>> i);
                y = y + (x_old >>> i);
                z = z - ATAN_TABLE[i];
            end
        end
        prod = x * GAIN_COMP;
        x    = DATA_W'(prod >>> FRAC_W);
        prod = y * GAIN_COMP;
        y    = DATA_W'(prod >>> FRAC_W);
        x_out = invert ? int'(-x) : int'(x);
        y_out = invert ? int'(-y) : int'(y);
        z_out = vec ? int'(-z) : int'(z);
    endtask

    task automatic check_value(input string name, input int got, input int want);
        if (got != want) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want);
            cur_ok = 1'b0;
        end
    endtask

    // Bus held until ack is seen mid-cycle and released after the ack edge
    task automatic access_bus(input bit we, input logic [WB_ADDR_W-1:0] adr,
                              input int wdata, output int rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata[WB_DATA_W-1:0];
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_WAIT);
        if (!wb_ack) begin
            $display("no ack from address %0d within %0d cycles", adr, ACK_WAIT);
            cur_ok = 1'b0;
        end
        rdata = int'($signed(wb_dat_r));
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [WB_ADDR_W-1:0] adr, input int data);
        int ignored;
        access_bus(1'b1, adr, data, ignored);
    endtask

    task automatic read_reg(input logic [WB_ADDR_W-1:0] adr, output int data);
        access_bus(1'b0, adr, 0, data);
    endtask

    task automatic wait_done();
        int status;
        int polls;
        status = 0;
        polls  = 0;
        while (status != 2 && polls < POLL_MAX) begin  // Done set and busy clear
            read_reg(ADDR_STATUS, status);
            polls++;
        end
        if (status != 2) begin
            $display("engine did not finish within %0d status polls", POLL_MAX);
            cur_ok = 1'b0;
        end
    endtask

    task automatic launch_op(input int x, input int y, input int z, input bit vec);
        write_reg(ADDR_X_IN, x);
        write_reg(ADDR_Y_IN, y);
        write_reg(ADDR_Z_IN, z);
        write_reg(ADDR_CTRL, vec ? 3 : 1);
    endtask

    task automatic compare_results(input int ex, input int ey, input int ez);
        int got;
        read_reg(ADDR_X_OUT, got);
        check_value("x_out", got, ex);
        read_reg(ADDR_Y_OUT, got);
        check_value("y_out", got, ey);
        read_reg(ADDR_Z_OUT, got);
        check_value("z_out", got, ez);
    endtask

    task automatic close_test(input string name);
        if (cur_ok) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int rd;
        int ex, ey, ez;
        int rx, ry, rz;
        bit rv;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        seed     = 32'h5fb7276a;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        cur_ok = 1'b1;
        read_reg(ADDR_STATUS, rd);
        check_value("status", rd, 0);
        write_reg(ADDR_X_IN, -1234);
        write_reg(ADDR_Y_IN, 8191);
        write_reg(ADDR_Z_IN, -8192);
        write_reg(ADDR_CTRL, 2);  // Mode only, no start
        read_reg(ADDR_X_IN, rd);
        check_value("x_in", rd, -1234);
        read_reg(ADDR_Y_IN, rd);
        check_value("y_in", rd, 8191);
        read_reg(ADDR_Z_IN, rd);
        check_value("z_in", rd, -8192);
        read_reg(ADDR_CTRL, rd);
        check_value("ctrl", rd, 2);
        close_test("reset_and_registers");

        for (int i = 0; i < N_DIR; i++) begin
            model_op(tbl_x[i], tbl_y[i], tbl_z[i], tbl_vec[i], exp_x[i], exp_y[i], exp_z[i]);
        end
        for (int i = 0; i < N_DIR; i++) begin
            cur_ok = 1'b1;
            launch_op(tbl_x[i], tbl_y[i], tbl_z[i], tbl_vec[i]);
            wait_done();
            compare_results(exp_x[i], exp_y[i], exp_z[i]);
            close_test($sformatf("%s_%0d", tbl_vec[i] ? "vectoring" : "rotation", i));
        end

        // Outputs hold the last directed result while the next one runs
        cur_ok = 1'b1;
        launch_op(2100, 1100, 900, 1'b0);
        read_reg(ADDR_STATUS, rd);
        check_value("status", rd, 1);
        compare_results(exp_x[N_DIR-1], exp_y[N_DIR-1], exp_z[N_DIR-1]);
        wait_done();
        model_op(2100, 1100, 900, 1'b0, ex, ey, ez);
        compare_results(ex, ey, ez);
        close_test("busy_and_done");

        cur_ok = 1'b1;
        launch_op(-1700, 1300, 0, 1'b1);
        write_reg(ADDR_X_IN, 900);
        write_reg(ADDR_Y_IN, -2200);
        write_reg(ADDR_Z_IN, 1600);
        write_reg(ADDR_CTRL, 1);  // Dropped while the engine runs
        read_reg(ADDR_CTRL, rd);
        check_value("ctrl", rd, 2);
        wait_done();
        model_op(-1700, 1300, 0, 1'b1, ex, ey, ez);
        compare_results(ex, ey, ez);
        write_reg(ADDR_CTRL, 1);
        wait_done();
        model_op(900, -2200, 1600, 1'b0, ex, ey, ez);
        compare_results(ex, ey, ez);
        close_test("writes_while_busy");

        for (int n = 0; n < N_RAND; n++) begin
            cur_ok = 1'b1;
            rx = $random(seed) % 2801;
            ry = $random(seed) % 2801;
            rz = $random(seed) % 2801;
            rv = ($random(seed) & 1) != 0;
            model_op(rx, ry, rz, rv, ex, ey, ez);
            launch_op(rx, ry, rz, rv);
            wait_done();
            compare_results(ex, ey, ez);
            close_test($sformatf("random_%0d", n));
        end

        $display("tests ok: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verif/cordic_props.sv
`timescale 1ns/100ps

module cordic_props import cordic_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic start_i,
    input logic done_i
);

    logic active;  // Engine between start and done

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (start_i) begin
            active <= 1'b1;
        end else if (done_i) begin
            active <= 1'b0;
        end
    end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else $error("wb_ack_o high without cyc and stb");

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_i |=> !wb_ack_i)
        else $error("wb_ack_o high for two cycles in a row");

    // No second start until the running operation is done
    start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !active)
        else $error("start issued while busy");

    done_timing: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> ##LATENCY done_i)
        else $error("done not %0d cycles after start", LATENCY);

endmodule

bind cordic_regs cordic_props props0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .start_i  (start_r),
    .done_i   (op.done)
);

//--- src/cordic_top.sv
`timescale 1ns/100ps

module cordic_top import cordic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack_o
);

    // Operation handoff between bus side and engine
    cordic_op_if op_if ();

    cordic_regs regs0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .op       (op_if.regs)
    );

    cordic_engine engine0 (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op_if.engine)
    );

endmodule

//--- src/cordic_engine.sv
`timescale 1ns/100ps

module cordic_engine import cordic_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    cordic_op_if.engine op
);

    // Working vector
    logic signed [DATA_W-1:0]   x_r;
    logic signed [DATA_W-1:0]   y_r;
    logic signed [DATA_W-1:0]   z_r;

    logic signed [DATA_W-1:0]   x_pre;
    logic signed [DATA_W-1:0]   y_pre;
    logic signed [DATA_W-1:0]   z_pre;
    logic                       inv_pre;
    logic                       z_low;
    logic                       z_high;

    logic signed [DATA_W-1:0]   x_sft;
    logic signed [DATA_W-1:0]   y_sft;
    logic signed [DATA_W-1:0]   x_step;
    logic signed [DATA_W-1:0]   y_step;
    logic signed [DATA_W-1:0]   z_step;
    logic                       down;

    logic signed [2*DATA_W-1:0] x_prod;
    logic signed [2*DATA_W-1:0] y_prod;
    logic signed [DATA_W-1:0]   x_gain;
    logic signed [DATA_W-1:0]   y_gain;

    logic [ITER_W-1:0]          iter_cnt;
    logic                       running;
    logic                       rotating;
    logic                       vec_r;
    logic                       inv_r;  // Rotation result needs negation

    assign z_low  = op.z_in < -Z_LIMIT - 14'sd1;
    assign z_high = op.z_in > Z_LIMIT;

    // Quadrant pre-correction
    always_comb begin
        x_pre   = op.x_in;
        y_pre   = op.y_in;
        z_pre   = op.z_in;
        inv_pre = 1'b0;
        if (op.vector_mode) begin
            z_pre = '0;
            if (op.x_in[DATA_W-1]) begin  // Left half plane folds by pi
                x_pre = -op.x_in;
                y_pre = -op.y_in;
                z_pre = op.y_in[DATA_W-1] ? -PI_FIXED : PI_FIXED;
            end
        end else if (z_low) begin
            z_pre   = op.z_in + PI_FIXED;
            inv_pre = 1'b1;
        end else if (z_high) begin
            z_pre   = op.z_in - PI_FIXED;
            inv_pre = 1'b1;
        end
    end

    // One micro-rotation
    always_comb begin
        x_sft = x_r >>> iter_cnt;
        y_sft = y_r >>> iter_cnt;
        down  = vec_r ? (!y_r[DATA_W-1] && (y_r != '0)) : z_r[DATA_W-1];
        if (down) begin
            x_step = x_r + y_sft;
            y_step = y_r - x_sft;
            z_step = z_r + ATAN_TABLE[iter_cnt];
        end else begin
            x_step = x_r - y_sft;
            y_step = y_r + x_sft;
            z_step = z_r - ATAN_TABLE[iter_cnt];
        end
    end

    // Gain compensation drops the fraction of the constant
    assign x_prod = x_r * GAIN_COMP;
    assign y_prod = y_r * GAIN_COMP;
    assign x_gain = x_prod[FRAC_W +: DATA_W];
    assign y_gain = y_prod[FRAC_W +: DATA_W];

    assign rotating = running && (iter_cnt != ITER_W'(ITERATIONS));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_r <= '0;
            y_r <= '0;
            z_r <= '0;
        end else if (op.start) begin
            x_r <= x_pre;
            y_r <= y_pre;
            z_r <= z_pre;
        end else if (rotating) begin
            x_r <= x_step;
            y_r <= y_step;
            z_r <= z_step;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            iter_cnt <= '0;
            vec_r    <= 1'b0;
            inv_r    <= 1'b0;
            op.done  <= 1'b0;
            op.x_out <= '0;
            op.y_out <= '0;
            op.z_out <= '0;
        end else begin
            op.done <= 1'b0;
            if (op.start) begin
                running  <= 1'b1;
                iter_cnt <= '0;
                vec_r    <= op.vector_mode;
                inv_r    <= inv_pre;
            end else if (rotating) begin
                iter_cnt <= iter_cnt + 1'b1;
            end else if (running) begin
                running  <= 1'b0;  // Gain cycle
                op.done  <= 1'b1;
                op.x_out <= inv_r ? -x_gain : x_gain;
                op.y_out <= inv_r ? -y_gain : y_gain;
                op.z_out <= vec_r ? -z_r : z_r;
            end
        end
    end

endmodule

//--- src/cordic_regs.sv
`timescale 1ns/100ps

module cordic_regs import cordic_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [WB_ADDR_W-1:0] wb_adr_i,
    input  logic [WB_DATA_W-1:0] wb_dat_i,
    output logic [WB_DATA_W-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    cordic_op_if.regs            op
);

    localparam int EXT_W = WB_DATA_W - DATA_W;

    logic                     access;
    logic                     wr_en;
    logic                     start_req;
    logic [WB_DATA_W-1:0]     rd_data;

    logic signed [DATA_W-1:0] x_in_r;
    logic signed [DATA_W-1:0] y_in_r;
    logic signed [DATA_W-1:0] z_in_r;
    logic                     mode_r;
    logic                     start_r;
    logic                     busy_r;
    logic                     done_r;  // Sticky until next start

    // Ack blocks a second access in the same bus cycle
    assign access    = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_en     = access && wb_we_i;
    assign start_req = wr_en && (wb_adr_i == ADDR_CTRL) && wb_dat_i[0] && !busy_r;

    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            ADDR_CTRL:   rd_data = {{(WB_DATA_W-2){1'b0}}, mode_r, 1'b0};
            ADDR_STATUS: rd_data = {{(WB_DATA_W-2){1'b0}}, done_r, busy_r};
            ADDR_X_IN:   rd_data = {{EXT_W{x_in_r[DATA_W-1]}}, x_in_r};
            ADDR_Y_IN:   rd_data = {{EXT_W{y_in_r[DATA_W-1]}}, y_in_r};
            ADDR_Z_IN:   rd_data = {{EXT_W{z_in_r[DATA_W-1]}}, z_in_r};
            ADDR_X_OUT:  rd_data = {{EXT_W{op.x_out[DATA_W-1]}}, op.x_out};
            ADDR_Y_OUT:  rd_data = {{EXT_W{op.y_out[DATA_W-1]}}, op.y_out};
            ADDR_Z_OUT:  rd_data = {{EXT_W{op.z_out[DATA_W-1]}}, op.z_out};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            x_in_r   <= '0;
            y_in_r   <= '0;
            z_in_r   <= '0;
            mode_r   <= 1'b0;
            start_r  <= 1'b0;
            busy_r   <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            wb_ack_o <= access;
            start_r  <= start_req;
            if (access && !wb_we_i) begin
                wb_dat_o <= rd_data;
            end
            if (wr_en) begin
                case (wb_adr_i)
                    ADDR_CTRL: begin
                        if (!busy_r) begin
                            mode_r <= wb_dat_i[1];  // Mode frozen while running
                        end
                    end
                    ADDR_X_IN: x_in_r <= wb_dat_i[DATA_W-1:0];
                    ADDR_Y_IN: y_in_r <= wb_dat_i[DATA_W-1:0];
                    ADDR_Z_IN: z_in_r <= wb_dat_i[DATA_W-1:0];
                    default: ;  // Read-only addresses acked and dropped
                endcase
            end
            if (start_req) begin
                busy_r <= 1'b1;
                done_r <= 1'b0;
            end else if (op.done) begin
                busy_r <= 1'b0;
                done_r <= 1'b1;
            end
        end
    end

    assign op.start       = start_r;
    assign op.vector_mode = mode_r;
    assign op.x_in        = x_in_r;
    assign op.y_in        = y_in_r;
    assign op.z_in        = z_in_r;

endmodule

//--- src/cordic_op_if.sv
`timescale 1ns/100ps

interface cordic_op_if import cordic_pkg::*; ();

    logic                     start;
    logic                     vector_mode;
    logic signed [DATA_W-1:0] x_in;
    logic signed [DATA_W-1:0] y_in;
    logic signed [DATA_W-1:0] z_in;

    logic signed [DATA_W-1:0] x_out;
    logic signed [DATA_W-1:0] y_out;
    logic signed [DATA_W-1:0] z_out;
    logic                     done;  // One cycle with fresh results

    modport regs (
        output start, vector_mode, x_in, y_in, z_in,
        input  x_out, y_out, z_out, done
    );

    modport engine (
        input  start, vector_mode, x_in, y_in, z_in,
        output x_out, y_out, z_out, done
    );

endinterface

//--- src/cordic_pkg.sv
package cordic_pkg;

    // Fixed-point word format
    localparam int DATA_W = 14;
    localparam int FRAC_W = 10;

    localparam int ITERATIONS = 12;
    localparam int ITER_W     = 4;

    // atan(2^-i) * 1024
    localparam logic signed [DATA_W-1:0] ATAN_TABLE [ITERATIONS] = '{
        14'sd804, 14'sd475, 14'sd251, 14'sd127, 14'sd64, 14'sd32,
        14'sd16,  14'sd8,   14'sd4,   14'sd2,   14'sd1,  14'sd0
    };

    localparam logic signed [DATA_W-1:0] PI_FIXED  = 14'sd3216;
    localparam logic signed [DATA_W-1:0] Z_LIMIT   = 14'sd1785;  // About 1.743 rad
    localparam logic signed [DATA_W-1:0] GAIN_COMP = 14'sd622;   // Inverse gain near 0.6074

    localparam int WB_DATA_W = 16;
    localparam int WB_ADDR_W = 3;

    // Register map in word addresses
    localparam logic [WB_ADDR_W-1:0] ADDR_CTRL   = 3'd0;
    localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 3'd1;
    localparam logic [WB_ADDR_W-1:0] ADDR_X_IN   = 3'd2;
    localparam logic [WB_ADDR_W-1:0] ADDR_Y_IN   = 3'd3;
    localparam logic [WB_ADDR_W-1:0] ADDR_Z_IN   = 3'd4;
    localparam logic [WB_ADDR_W-1:0] ADDR_X_OUT  = 3'd5;
    localparam logic [WB_ADDR_W-1:0] ADDR_Y_OUT  = 3'd6;
    localparam logic [WB_ADDR_W-1:0] ADDR_Z_OUT  = 3'd7;

    localparam int LATENCY = 14;  // Start pulse to done pulse

endpackage
